// ==== all.f ====
+incdir+tests
verilog/axi_chan_pkg.sv
verilog/ll_frame_pkg.sv
verilog/ll_credit_tx.sv
verilog/ll_rx_fifo.sv
verilog/ll_phy_framer.sv
verilog/aximm_ll_master_top.sv
tests/tb_aximm_ll_master.sv

// ==== tests/tb_ref.svh ====
// Reference LFSR and expected PHY word layouts for the link-layer master testbench
`ifndef tb_ref_svh
`define tb_ref_svh

// 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
  logic fb;
  fb = state[15] ^ state[13] ^ state[12] ^ state[10];
  return {state[14:0], fb};
endfunction

////////////////////////////////////////
// Transmit word with an optional AR request and an R credit

function automatic logic [phy_w-1:0] ar_tx_word(
  input logic               push,
  input logic [id_w-1:0]    id,
  input logic [addr_w-1:0]  addr,
  input logic [size_w-1:0]  size,
  input logic [len_w-1:0]   len,
  input logic [burst_w-1:0] burst,
  input logic               r_cred
);
  logic [phy_w-1:0] word;
  word = '0;
  word[push_pos] = push;
  // Payload is zero unless a request travels
  if (push) begin
    word[tx_ar_lsb +: ar_payload_w] = {id, addr, size, len, burst};
  end
  word[tx_rcred_pos] = r_cred;
  return word;
endfunction

////////////////////////////////////////
// Receive word with an optional R beat and an AR credit

function automatic logic [phy_w-1:0] r_rx_word(
  input logic              push,
  input logic [id_w-1:0]   id,
  input logic [data_w-1:0] data,
  input logic              last,
  input logic [resp_w-1:0] resp,
  input logic              ar_cred
);
  logic [phy_w-1:0] word;
  word = '0;
  word[push_pos] = push;
  word[rx_r_lsb +: r_payload_w] = {id, data, last, resp};
  word[rx_arcred_pos] = ar_cred;
  return word;
endfunction

`endif

// ==== tests/tb_aximm_ll_master.sv ====
// Testbench for the read-only AXI master over the credit-based logic link
`timescale 1ns/10ps

module tb_aximm_ll_master
  import axi_chan_pkg::*;
  import ll_frame_pkg::*;
();

  localparam int rx_depth = 8;

  logic                clk_wr;
  logic                rst_n;
  logic                tx_online;
  logic                rx_online;
  logic [cred_w-1:0]   init_ar_credit;
  logic [phy_w-1:0]    tx_phy;
  logic [phy_w-1:0]    rx_phy;
  logic [id_w-1:0]     user_arid;
  logic [size_w-1:0]   user_arsize;
  logic [len_w-1:0]    user_arlen;
  logic [burst_w-1:0]  user_arburst;
  logic [addr_w-1:0]   user_araddr;
  logic                user_arvalid;
  logic                user_arready;
  logic [id_w-1:0]     user_rid;
  logic [data_w-1:0]   user_rdata;
  logic                user_rlast;
  logic [resp_w-1:0]   user_rresp;
  logic                user_rvalid;
  logic                user_rready;

  // Models of the DUT state, updated at every rising edge
  logic                   link_m;
  logic [cred_w-1:0]      cred_m;
  int                     rcnt_m;
  logic [phy_w-1:0]       exp_tx;
  logic [r_payload_w-1:0] exp_r[$];
  int                     edge_cnt;
  int                     acc_cnt;
  int                     pops;
  int                     cred_bits;
  logic [15:0]            lfsr_state;
  string                  test_name;
  int                     c0;
  int                     p0;

  `include "tb_ref.svh"

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] val;
    int          i;
    val = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[62:0], lfsr_state[0]};
    end
    return val;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    assert (actual === expected) else
      fail_run($sformatf("mismatch %s %s expected %h actual %h",
                         test_name, name, expected, actual));
  endtask

  function automatic bit reached(input string what, input int target);
    case (what)
      "accepts": return acc_cnt >= target;
      "link":    return link_m == target;
      default:   return exp_r.size() == target;
    endcase
  endfunction

  task automatic wait_for(input string what, input int target);
    int waited;
    waited = 0;
    while (!reached(what, target)) begin
      @(negedge clk_wr);
      waited++;
      if (waited > 200) begin
        fail_run($sformatf("timeout waiting for %s in %s", what, test_name));
      end
    end
  endtask

  ////////////////////////////////////////
  // Stimulus helpers, called on the falling edge

  task automatic send_ar();
    user_arid    = rand_bits(id_w);
    user_araddr  = rand_bits(addr_w);
    user_arsize  = rand_bits(size_w);
    user_arlen   = rand_bits(len_w);
    user_arburst = rand_bits(burst_w);
    user_arvalid = 1'b1;
    wait_for("accepts", acc_cnt + 1);
    user_arvalid = 1'b0;
  endtask

  task automatic push_beat();
    logic [id_w-1:0]   id;
    logic [data_w-1:0] data;
    logic              last;
    logic [resp_w-1:0] resp;
    id   = rand_bits(id_w);
    data = rand_bits(data_w);
    last = rand_bits(1);
    resp = rand_bits(resp_w);
    rx_phy = r_rx_word(1'b1, id, data, last, resp, 1'b0);
    exp_r.push_back({id, data, last, resp});
    @(negedge clk_wr);
    rx_phy = '0;
  endtask

  aximm_ll_master_top #(
    .rx_depth (rx_depth)
  ) i_dut (
    .clk_wr         (clk_wr),
    .rst_n          (rst_n),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .init_ar_credit (init_ar_credit),
    .tx_phy         (tx_phy),
    .rx_phy         (rx_phy),
    .user_arid      (user_arid),
    .user_arsize    (user_arsize),
    .user_arlen     (user_arlen),
    .user_arburst   (user_arburst),
    .user_araddr    (user_araddr),
    .user_arvalid   (user_arvalid),
    .user_arready   (user_arready),
    .user_rid       (user_rid),
    .user_rdata     (user_rdata),
    .user_rlast     (user_rlast),
    .user_rresp     (user_rresp),
    .user_rvalid    (user_rvalid),
    .user_rready    (user_rready)
  );

  initial begin
    clk_wr = 1'b0;
    forever #20 clk_wr = ~clk_wr;
  end

  ////////////////////////////////////////
  // Comparison against the models

  always @(posedge clk_wr) begin : compare
    logic                   acc_m;
    logic                   pop_m;
    logic                   link_next;
    logic [r_payload_w-1:0] beat;
    acc_m = user_arvalid && link_m && (cred_m != '0);
    pop_m = (rcnt_m != 0) && user_rready;
    // Registers hold X until the first reset edge
    if (edge_cnt > 0) begin
      check_value("tx_phy", exp_tx, tx_phy);
      check_value("user_arready", link_m && cred_m != '0, user_arready);
      check_value("user_rvalid", rcnt_m != 0, user_rvalid);
      if (pop_m) begin
        assert (exp_r.size() != 0) else fail_run("R beat delivered with none expected");
        beat = exp_r.pop_front();
        check_value("r beat", beat, {user_rid, user_rdata, user_rlast, user_rresp});
      end
    end
    if (tx_phy[tx_rcred_pos] === 1'b1) begin
      cred_bits++;
    end
    // Handshakes seen on the DUT ports
    if (user_arvalid === 1'b1 && user_arready === 1'b1) begin
      acc_cnt++;
    end
    if (user_rvalid === 1'b1 && user_rready === 1'b1) begin
      pops++;
    end
    // Next state of link, transmit word, credits and FIFO fill
    link_next = rst_n && tx_online && rx_online;
    exp_tx = link_next ? ar_tx_word(acc_m, user_arid, user_araddr, user_arsize,
                                    user_arlen, user_arburst, pop_m) : '0;
    if (!rst_n) begin
      cred_m = '0;
    end else if (!link_m) begin
      cred_m = init_ar_credit;
    end else begin
      cred_m = cred_m + rx_phy[rx_arcred_pos] - acc_m;
    end
    if (!rst_n || !link_m) begin
      rcnt_m = 0;
    end else begin
      rcnt_m = rcnt_m + (rx_phy[push_pos] && rcnt_m < rx_depth) - pop_m;
    end
    link_m = link_next;
    edge_cnt++;
  end

  initial begin
    rst_n = 1'b0;
    tx_online = 1'b0;
    rx_online = 1'b0;
    init_ar_credit = 8'd8;
    rx_phy = '0;
    user_arid = '0;
    user_arsize = '0;
    user_arlen = '0;
    user_arburst = '0;
    user_araddr = '0;
    user_arvalid = 1'b1;
    user_rready = 1'b0;
    link_m = 1'b0;
    cred_m = '0;
    rcnt_m = 0;
    exp_tx = '0;
    edge_cnt = 0;
    acc_cnt = 0;
    pops = 0;
    cred_bits = 0;
    lfsr_state = 16'd50;

    test_name = "link_down";
    repeat (8) @(negedge clk_wr);
    rst_n = 1'b1;
    tx_online = 1'b1;
    repeat (4) @(negedge clk_wr);
    tx_online = 1'b0;
    rx_online = 1'b1;
    repeat (4) @(negedge clk_wr);
    user_arvalid = 1'b0;

    test_name = "ar_framing";
    tx_online = 1'b1;
    wait_for("link", 1);
    repeat (8) send_ar();

    // Link down reloads the credit counter
    test_name = "credit_limit";
    init_ar_credit = 8'd3;
    tx_online = 1'b0;
    wait_for("link", 0);
    tx_online = 1'b1;
    wait_for("link", 1);
    c0 = acc_cnt;
    repeat (3) send_ar();
    user_arvalid = 1'b1;
    repeat (10) @(negedge clk_wr);
    check_value("accepts at zero credit", c0 + 3, acc_cnt);
    rx_phy = r_rx_word(1'b0, '0, '0, 1'b0, '0, 1'b1);
    @(negedge clk_wr);
    rx_phy = '0;
    wait_for("accepts", c0 + 4);
    repeat (10) @(negedge clk_wr);
    check_value("accepts after one credit", c0 + 4, acc_cnt);
    user_arvalid = 1'b0;

    test_name = "r_delivery";
    user_rready = 1'b1;
    repeat (12) push_beat();
    wait_for("drain", 0);

    test_name = "r_backpressure";
    user_rready = 1'b0;
    repeat (2) @(negedge clk_wr);
    c0 = cred_bits;
    p0 = pops;
    repeat (rx_depth) push_beat();
    repeat (4) @(negedge clk_wr);
    check_value("credits while stalled", c0, cred_bits);
    user_rready = 1'b1;
    wait_for("drain", 0);
    repeat (2) @(negedge clk_wr);
    check_value("pops", p0 + rx_depth, pops);
    check_value("credit bits", pops - p0, cred_bits - c0);

    $display("All checks passed");
    $finish;
  end

endmodule

// ==== verilog/aximm_ll_master_top.sv ====
// Read-only AXI master over a credit-based logic link
`timescale 1ns/10ps

module aximm_ll_master_top
  import axi_chan_pkg::*;
  import ll_frame_pkg::*;
#(
  parameter int rx_depth = 8
) (
  input  logic                 clk_wr,
  input  logic                 rst_n,

  // Link control
  input  logic                 tx_online,
  input  logic                 rx_online,
  input  logic [cred_w-1:0]    init_ar_credit,

  // PHY words
  output logic [phy_w-1:0]     tx_phy,
  input  logic [phy_w-1:0]     rx_phy,

  // AR channel
  input  logic [id_w-1:0]      user_arid,
  input  logic [size_w-1:0]    user_arsize,
  input  logic [len_w-1:0]     user_arlen,
  input  logic [burst_w-1:0]   user_arburst,
  input  logic [addr_w-1:0]    user_araddr,
  input  logic                 user_arvalid,
  output logic                 user_arready,

  // R channel
  output logic [id_w-1:0]      user_rid,
  output logic [data_w-1:0]    user_rdata,
  output logic                 user_rlast,
  output logic [resp_w-1:0]    user_rresp,
  output logic                 user_rvalid,
  input  logic                 user_rready
);

  ////////////////////////////////////////
  // Internal wires

  logic                    link_up;
  logic                    ar_push;
  logic [ar_payload_w-1:0] ar_payload;
  logic                    ar_credit;
  logic                    r_push;
  logic [r_payload_w-1:0]  r_payload;
  logic                    r_credit;

  ////////////////////////////////////////
  // PHY framing

  ll_phy_framer i_framer (
    .clk_wr     (clk_wr),
    .rst_n      (rst_n),
    .tx_online  (tx_online),
    .rx_online  (rx_online),
    .link_up    (link_up),
    .ar_push    (ar_push),
    .ar_payload (ar_payload),
    .r_credit   (r_credit),
    .tx_phy     (tx_phy),
    .rx_phy     (rx_phy),
    .r_push     (r_push),
    .r_payload  (r_payload),
    .ar_credit  (ar_credit)
  );

  ////////////////////////////////////////
  // AR transmit and R receive

  ll_credit_tx i_credit_tx (
    .clk_wr         (clk_wr),
    .rst_n          (rst_n),
    .link_up        (link_up),
    .init_ar_credit (init_ar_credit),
    .ar_credit      (ar_credit),
    .user_arid      (user_arid),
    .user_arsize    (user_arsize),
    .user_arlen     (user_arlen),
    .user_arburst   (user_arburst),
    .user_araddr    (user_araddr),
    .user_arvalid   (user_arvalid),
    .user_arready   (user_arready),
    .ar_push        (ar_push),
    .ar_payload     (ar_payload)
  );

  ll_rx_fifo #(
    .rx_depth (rx_depth)
  ) i_rx_fifo (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .link_up     (link_up),
    .r_push      (r_push),
    .r_payload   (r_payload),
    .user_rid    (user_rid),
    .user_rdata  (user_rdata),
    .user_rlast  (user_rlast),
    .user_rresp  (user_rresp),
    .user_rvalid (user_rvalid),
    .user_rready (user_rready),
    .r_credit    (r_credit)
  );

endmodule

// ==== verilog/ll_phy_framer.sv ====
// PHY-side framer with link-up status and packing of transmit and receive words
`timescale 1ns/10ps

module ll_phy_framer
  import axi_chan_pkg::*;
  import ll_frame_pkg::*;
(
  input  logic                    clk_wr,
  input  logic                    rst_n,

  input  logic                    tx_online,
  input  logic                    rx_online,
  output logic                    link_up,

  // Transmit side
  input  logic                    ar_push,
  input  logic [ar_payload_w-1:0] ar_payload,
  input  logic                    r_credit,
  output logic [phy_w-1:0]        tx_phy,

  // Receive side
  input  logic [phy_w-1:0]        rx_phy,
  output logic                    r_push,
  output logic [r_payload_w-1:0]  r_payload,
  output logic                    ar_credit
);

  ////////////////////////////////////////
  // Link status

  // Both directions must be online
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      link_up <= 1'b0;
    end else begin
      link_up <= tx_online && rx_online;
    end
  end

  ////////////////////////////////////////
  // Transmit word

  always_comb begin
    tx_phy = '0;
    if (link_up) begin
      tx_phy[push_pos] = ar_push;
      // Payload only travels alongside a push
      tx_phy[tx_ar_lsb +: ar_payload_w] = ar_push ? ar_payload : '0;
      tx_phy[tx_rcred_pos] = r_credit;
    end
  end

  ////////////////////////////////////////
  // Receive word

  assign r_push    = rx_phy[push_pos];
  assign r_payload = rx_phy[rx_r_lsb +: r_payload_w];
  assign ar_credit = rx_phy[rx_arcred_pos];

endmodule

// ==== verilog/ll_rx_fifo.sv ====
// R receiver FIFO that hands beats to the user and returns one credit per pop
`timescale 1ns/10ps

module ll_rx_fifo
  import axi_chan_pkg::*;
#(
  parameter int rx_depth = 8
) (
  input  logic                   clk_wr,
  input  logic                   rst_n,

  input  logic                   link_up,

  // From the framer
  input  logic                   r_push,
  input  logic [r_payload_w-1:0] r_payload,

  // User R channel
  output logic [id_w-1:0]        user_rid,
  output logic [data_w-1:0]      user_rdata,
  output logic                   user_rlast,
  output logic [resp_w-1:0]      user_rresp,
  output logic                   user_rvalid,
  input  logic                   user_rready,

  // Credit back to the far side
  output logic                   r_credit
);

  localparam int ptr_w = $clog2(rx_depth);

  // One extra pointer bit tells full from empty
  logic [ptr_w:0]           wr_ptr;
  logic [ptr_w:0]           rd_ptr;
  logic [r_payload_w-1:0]   fifo_mem [rx_depth];
  logic [r_payload_w-1:0]   head_beat;
  logic                     fifo_empty;
  logic                     fifo_full;
  logic                     push_en;
  logic                     pop_en;

  ////////////////////////////////////////
  // Pointers and status

  assign fifo_empty = (wr_ptr == rd_ptr);
  assign fifo_full  = (wr_ptr[ptr_w] != rd_ptr[ptr_w]) &&
                      (wr_ptr[ptr_w-1:0] == rd_ptr[ptr_w-1:0]);

  // Beat into a full FIFO is lost
  assign push_en = r_push && link_up && !fifo_full;
  assign pop_en  = user_rvalid && user_rready;

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (!link_up) begin
      // Flush while the link is down
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_wr) begin
    if (push_en) begin
      fifo_mem[wr_ptr[ptr_w-1:0]] <= r_payload;
    end
  end

  ////////////////////////////////////////
  // Head beat to the user

  assign head_beat   = fifo_mem[rd_ptr[ptr_w-1:0]];
  assign user_rvalid = !fifo_empty;
  assign user_rresp  = head_beat[resp_w-1:0];
  assign user_rlast  = head_beat[resp_w];
  assign user_rdata  = head_beat[resp_w+1 +: data_w];
  assign user_rid    = head_beat[resp_w+1+data_w +: id_w];

  // Credit pulse one cycle after each pop
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      r_credit <= 1'b0;
    end else begin
      r_credit <= pop_en;
    end
  end

endmodule

// ==== verilog/ll_credit_tx.sv ====
// AR transmitter that spends one link credit per accepted request
`timescale 1ns/10ps

module ll_credit_tx
  import axi_chan_pkg::*;
  import ll_frame_pkg::*;
(
  input  logic                    clk_wr,
  input  logic                    rst_n,

  input  logic                    link_up,
  input  logic [cred_w-1:0]       init_ar_credit,
  input  logic                    ar_credit,

  // User AR channel
  input  logic [id_w-1:0]         user_arid,
  input  logic [size_w-1:0]       user_arsize,
  input  logic [len_w-1:0]        user_arlen,
  input  logic [burst_w-1:0]      user_arburst,
  input  logic [addr_w-1:0]       user_araddr,
  input  logic                    user_arvalid,
  output logic                    user_arready,

  // Towards the framer
  output logic                    ar_push,
  output logic [ar_payload_w-1:0] ar_payload
);

  logic [cred_w-1:0] ar_cred_cnt;
  logic              ar_accept;

  ////////////////////////////////////////
  // Credit counter

  // Ready only with the link up and at least one credit left
  assign user_arready = link_up && (ar_cred_cnt != '0);
  assign ar_accept    = user_arvalid && user_arready;

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      ar_cred_cnt <= '0;
    end else if (!link_up) begin
      ar_cred_cnt <= init_ar_credit;
    end else begin
      // Accept and returned credit in one cycle cancel out
      case ({ar_accept, ar_credit})
        2'b10:   ar_cred_cnt <= ar_cred_cnt - 1'b1;
        2'b01:   ar_cred_cnt <= ar_cred_cnt + 1'b1;
        default: ar_cred_cnt <= ar_cred_cnt;
      endcase
    end
  end

  ////////////////////////////////////////
  // Request register

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      ar_push <= 1'b0;
    end else begin
      ar_push <= ar_accept;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (ar_accept) begin
      ar_payload <= {user_arid, user_araddr, user_arsize, user_arlen, user_arburst};
    end
  end

endmodule

// ==== verilog/ll_frame_pkg.sv ====
// PHY word width and field positions of the logic link in both directions
package ll_frame_pkg;

  ////////////////////////////////////////
  // Common

  // Width of one PHY word per clock
  localparam int phy_w = 79;

  // Push bit sits in the same place on both sides
  localparam int push_pos = 0;

  // Credit counter size in the transmitter
  localparam int cred_w = 8;

  ////////////////////////////////////////
  // Transmit word

  // AR payload occupies bits 1 to 49
  localparam int tx_ar_lsb = 1;

  // Credit returned for each R beat popped
  localparam int tx_rcred_pos = 50;

  ////////////////////////////////////////
  // Receive word

  // R payload occupies bits 1 to 71
  localparam int rx_r_lsb = 1;

  // Credit from the far side for one AR request
  localparam int rx_arcred_pos = 72;

endpackage

// ==== verilog/axi_chan_pkg.sv ====
// AXI read-channel field widths shared by the link-layer master
package axi_chan_pkg;

  ////////////////////////////////////////
  // AR channel fields

  localparam int id_w    = 4;
  localparam int addr_w  = 32;
  localparam int len_w   = 8;
  localparam int size_w  = 3;
  localparam int burst_w = 2;

  ////////////////////////////////////////
  // R channel fields

  localparam int data_w = 64;
  localparam int resp_w = 2;

  ////////////////////////////////////////
  // Packed channel words

  // AR word holds burst lowest and id highest
  localparam int ar_payload_w = burst_w + len_w + size_w + addr_w + id_w;

  // R word holds resp lowest, then last, data and id
  localparam int r_payload_w = resp_w + 1 + data_w + id_w;

endpackage
